// File: hw/rv_arch_pkg.sv
`default_nettype none

package rv_arch_pkg;

    // Machine word and CSR field widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned CSR_ADDR_W = 12;

    // One line per machine interrupt cause
    localparam int unsigned IRQ_W    = 32;
    localparam int unsigned IRQ_ID_W = 5;

    // Only the CSRs that decide interrupt enabling are snooped
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MIE     = 12'h304
    } csr_addr_e;

    // Global machine interrupt enable inside mstatus
    localparam int unsigned MSTATUS_MIE_BIT = 3;

    // Return from debug mode
    localparam logic [XLEN-1:0] INSN_DRET = 32'h7b20_0073;

endpackage

`default_nettype wire

// File: hw/shadow_pipe_pkg.sv
`default_nettype none

package shadow_pipe_pkg;

    // IF, ID, EX and WB
    localparam int unsigned PIPE_DEPTH = 4;

    // Steps without commit needed before WB lines up with the core
    localparam int unsigned FILL_STEPS = PIPE_DEPTH - 1;
    localparam int unsigned FILL_CNT_W = 2;

    // Predicted instruction as delivered by the upstream model
    typedef struct packed {
        logic [rv_arch_pkg::XLEN-1:0]       order;
        logic [rv_arch_pkg::XLEN-1:0]       insn;
        logic                               csr_we;
        logic [rv_arch_pkg::CSR_ADDR_W-1:0] csr_addr;
        logic [rv_arch_pkg::XLEN-1:0]       csr_wdata;
        logic                               dbg_mode;
    } instr_rec_t;

    typedef struct packed {
        instr_rec_t rec;
        logic       valid;
    } stage_t;

    typedef enum logic {
        FILLING,
        RUNNING
    } fill_state_e;

endpackage

`default_nettype wire

// File: hw/stage_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_ctrl_if;

    // Steps IF to EX, held low while a debug entry stalls the front
    logic front_step;
    // Steps WB, follows the commit stream once the pipeline is full
    logic wb_step;
    logic flush;
    logic pipe_full;

    modport ctrl (output front_step, output wb_step, output flush, output pipe_full);

    modport pipe (input front_step, input wb_step, input flush);

    // Trackers watch the steps and block new takes while a flush is in flight
    modport mon (input wb_step, input flush, input pipe_full);

endinterface

`default_nettype wire

// File: hw/retire_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module retire_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    stage_ctrl_if.pipe                  ctrl,
    input  shadow_pipe_pkg::instr_rec_t rec_i,
    input  logic                        rec_valid_i,
    output shadow_pipe_pkg::stage_t     ex_wb_o,
    output shadow_pipe_pkg::stage_t     wb_o,
    output logic                        retire_valid_o
);

    // Front stages are indexed IF = 0, ID = 1, EX = 2
    shadow_pipe_pkg::instr_rec_t              front_rec [shadow_pipe_pkg::PIPE_DEPTH-1];
    logic [shadow_pipe_pkg::PIPE_DEPTH-2:0]   front_vld;

    shadow_pipe_pkg::instr_rec_t wb_rec;
    logic                        wb_vld;
    logic                        retire_q;

    ////////////////////////////////////////
    // Record payload
    ////////////////////////////////////////

    // Payload moves on every step, a flush only drops the valid bits
    always_ff @(posedge clk) begin
        if (ctrl.front_step) begin
            front_rec[0] <= rec_i;
            for (int i = 1; i < shadow_pipe_pkg::PIPE_DEPTH - 1; i++) begin
                front_rec[i] <= front_rec[i-1];
            end
        end
        if (ctrl.wb_step) begin
            wb_rec <= front_rec[shadow_pipe_pkg::PIPE_DEPTH-2];
        end
    end

    ////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            front_vld <= '0;
            wb_vld    <= 1'b0;
            retire_q  <= 1'b0;
        end else begin
            // One pulse per valid record entering WB, never on a flush
            retire_q <= ctrl.wb_step && !ctrl.flush
                        && front_vld[shadow_pipe_pkg::PIPE_DEPTH-2];
            if (ctrl.flush) begin
                front_vld <= '0;
                wb_vld    <= 1'b0;
            end else begin
                if (ctrl.front_step) begin
                    front_vld <= {front_vld[shadow_pipe_pkg::PIPE_DEPTH-3:0], rec_valid_i};
                end
                // During a debug stall WB still takes what sits in EX
                if (ctrl.wb_step) begin
                    wb_vld <= front_vld[shadow_pipe_pkg::PIPE_DEPTH-2];
                end
            end
        end
    end

    assign ex_wb_o = '{
        rec:   front_rec[shadow_pipe_pkg::PIPE_DEPTH-2],
        valid: front_vld[shadow_pipe_pkg::PIPE_DEPTH-2]
    };

    assign wb_o = '{
        rec:   wb_rec,
        valid: wb_vld
    };

    assign retire_valid_o = retire_q;

endmodule

`default_nettype wire

// File: hw/irq_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module irq_tracker (
    input  logic                             clk,
    input  logic                             rst_n,
    stage_ctrl_if.mon                        mon,
    input  shadow_pipe_pkg::stage_t          ex_wb_i,
    input  logic                             debug_mode_i,
    input  logic [rv_arch_pkg::IRQ_W-1:0]    irq_i,
    output logic                             irq_taken_o,
    output logic [rv_arch_pkg::IRQ_ID_W-1:0] irq_id_o
);

    logic                             csr_hit;
    logic                             mie_wr;
    logic                             mstatus_mie_set;
    logic [rv_arch_pkg::IRQ_W-1:0]    mie_q;
    logic                             irq_en_q;
    logic [rv_arch_pkg::IRQ_W-1:0]    irq_q;
    logic [rv_arch_pkg::IRQ_W-1:0]    irq_qq;
    logic [rv_arch_pkg::IRQ_W-1:0]    pending;
    logic                             take;
    logic [rv_arch_pkg::IRQ_ID_W-1:0] irq_id_d;
    logic                             irq_taken_q;
    logic [rv_arch_pkg::IRQ_ID_W-1:0] irq_id_q;

    ////////////////////////////////////////
    // CSR snooping
    ////////////////////////////////////////

    // CSR writes take effect when their record moves from EX into WB
    assign csr_hit = mon.wb_step && !mon.flush && ex_wb_i.valid && ex_wb_i.rec.csr_we;

    assign mie_wr          = csr_hit && (ex_wb_i.rec.csr_addr == rv_arch_pkg::CSR_MIE);
    assign mstatus_mie_set = csr_hit && (ex_wb_i.rec.csr_addr == rv_arch_pkg::CSR_MSTATUS)
                             && ex_wb_i.rec.csr_wdata[rv_arch_pkg::MSTATUS_MIE_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q    <= '0;
            irq_en_q <= 1'b0;
        end else begin
            if (mie_wr) begin
                mie_q <= ex_wb_i.rec.csr_wdata[rv_arch_pkg::IRQ_W-1:0];
            end
            // The trap handler entry clears mstatus.MIE on the core side
            if (mstatus_mie_set) begin
                irq_en_q <= 1'b1;
            end else if (irq_taken_q) begin
                irq_en_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Interrupt decision
    ////////////////////////////////////////

    // Two cycles of delay so the take lands on the flushed boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q  <= '0;
            irq_qq <= '0;
        end else begin
            irq_q  <= irq_i;
            irq_qq <= irq_q;
        end
    end

    assign pending = irq_qq & mie_q;
    assign take    = irq_en_q && mon.pipe_full && !debug_mode_i && !mon.flush && (|pending);

    // Lowest pending line has priority
    always_comb begin
        irq_id_d = '0;
        for (int i = rv_arch_pkg::IRQ_W - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_id_d = i[rv_arch_pkg::IRQ_ID_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_taken_q <= 1'b0;
            irq_id_q    <= '0;
        end else begin
            irq_taken_q <= take;
            if (take) begin
                irq_id_q <= irq_id_d;
            end
        end
    end

    assign irq_taken_o = irq_taken_q;
    assign irq_id_o    = irq_id_q;

endmodule

`default_nettype wire

// File: hw/debug_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module debug_tracker (
    input  logic                    clk,
    input  logic                    rst_n,
    stage_ctrl_if.mon               mon,
    input  shadow_pipe_pkg::stage_t wb_i,
    input  logic                    debug_req_i,
    output logic                    debug_taken_o,
    output logic                    debug_mode_o
);

    logic debug_mode;
    logic debug_req_q;
    logic debug_taken_q;

    // The DRET record itself still reports dbg_mode, but debug mode
    // already ends with it
    assign debug_mode = wb_i.valid && wb_i.rec.dbg_mode
                        && (wb_i.rec.insn != rv_arch_pkg::INSN_DRET);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_req_q   <= 1'b0;
            debug_taken_q <= 1'b0;
        end else begin
            debug_req_q <= debug_req_i;
            // No entry while filling, and one pulse per entry
            debug_taken_q <= debug_req_q && !debug_mode && mon.pipe_full
                             && !mon.flush && !debug_taken_q;
        end
    end

    assign debug_taken_o = debug_taken_q;
    assign debug_mode_o  = debug_mode;

endmodule

`default_nettype wire

// File: hw/step_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module step_flush_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        commit_i,
    input  logic        irq_taken_i,
    input  logic        debug_taken_i,
    stage_ctrl_if.ctrl  ctrl
);

    shadow_pipe_pkg::fill_state_e             state_q;
    logic [shadow_pipe_pkg::FILL_CNT_W-1:0]   fill_cnt_q;
    logic                                     debug_taken_q;
    logic                                     flush;
    logic                                     wb_step;

    ////////////////////////////////////////
    // Fill and step
    ////////////////////////////////////////

    // The stages step on their own until the record for the next
    // commit sits in EX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= shadow_pipe_pkg::FILLING;
            fill_cnt_q <= '0;
        end else if (flush) begin
            state_q    <= shadow_pipe_pkg::FILLING;
            fill_cnt_q <= '0;
        end else if (state_q == shadow_pipe_pkg::FILLING) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
            if (int'(fill_cnt_q) == shadow_pipe_pkg::FILL_STEPS - 1) begin
                state_q <= shadow_pipe_pkg::RUNNING;
            end
        end
    end

    assign wb_step = (state_q == shadow_pipe_pkg::FILLING) ? 1'b1 : commit_i;

    ////////////////////////////////////////
    // Flush
    ////////////////////////////////////////

    // A debug entry first lets WB retire, the flush follows one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_taken_q <= 1'b0;
        end else begin
            debug_taken_q <= debug_taken_i;
        end
    end

    assign flush = irq_taken_i || debug_taken_q;

    assign ctrl.wb_step    = wb_step;
    assign ctrl.front_step = wb_step && !debug_taken_i;
    assign ctrl.flush      = flush;
    assign ctrl.pipe_full  = (state_q == shadow_pipe_pkg::RUNNING);

endmodule

`default_nettype wire

// File: hw/retire_shadow_top.sv
`timescale 1ns/1ps
`default_nettype none

module retire_shadow_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             commit_i,
    input  shadow_pipe_pkg::instr_rec_t      rec_i,
    input  logic                             rec_valid_i,
    input  logic [rv_arch_pkg::IRQ_W-1:0]    irq_i,
    input  logic                             debug_req_i,
    output logic                             retire_valid_o,
    output shadow_pipe_pkg::instr_rec_t      retire_rec_o,
    output logic                             irq_taken_o,
    output logic [rv_arch_pkg::IRQ_ID_W-1:0] irq_id_o,
    output logic                             debug_taken_o
);

    shadow_pipe_pkg::stage_t ex_wb;
    shadow_pipe_pkg::stage_t wb;
    logic                    irq_taken;
    logic                    debug_taken;
    logic                    debug_mode;

    stage_ctrl_if stage_if ();

    step_flush_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_i      (commit_i),
        .irq_taken_i   (irq_taken),
        .debug_taken_i (debug_taken),
        .ctrl          (stage_if.ctrl)
    );

    retire_pipe u_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (stage_if.pipe),
        .rec_i          (rec_i),
        .rec_valid_i    (rec_valid_i),
        .ex_wb_o        (ex_wb),
        .wb_o           (wb),
        .retire_valid_o (retire_valid_o)
    );

    irq_tracker u_irq (
        .clk          (clk),
        .rst_n        (rst_n),
        .mon          (stage_if.mon),
        .ex_wb_i      (ex_wb),
        .debug_mode_i (debug_mode),
        .irq_i        (irq_i),
        .irq_taken_o  (irq_taken),
        .irq_id_o     (irq_id_o)
    );

    debug_tracker u_dbg (
        .clk           (clk),
        .rst_n         (rst_n),
        .mon           (stage_if.mon),
        .wb_i          (wb),
        .debug_req_i   (debug_req_i),
        .debug_taken_o (debug_taken),
        .debug_mode_o  (debug_mode)
    );

    // The retiring record is whatever sits in WB
    assign retire_rec_o  = wb.rec;
    assign irq_taken_o   = irq_taken;
    assign debug_taken_o = debug_taken;

endmodule

`default_nettype wire

// File: testbench/tb_retire_shadow.sv
`timescale 1ns/1ps
`default_nettype none

module tb_retire_shadow;

    typedef enum int {WAIT_IRQ, WAIT_DBG, WAIT_DBG_RETIRE, WAIT_DRET_RETIRE} wait_kind_e;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    logic                                 commit_i;
    shadow_pipe_pkg::instr_rec_t          rec_i;
    logic                                 rec_valid_i;
    logic [rv_arch_pkg::IRQ_W-1:0]        irq_i;
    logic                                 debug_req_i;
    logic                                 retire_valid_o;
    shadow_pipe_pkg::instr_rec_t          retire_rec_o;
    logic                                 irq_taken_o;
    logic [rv_arch_pkg::IRQ_ID_W-1:0]     irq_id_o;
    logic                                 debug_taken_o;

    // Scenario values that tick copies into the applied versions at the next rising edge
    logic [rv_arch_pkg::IRQ_W-1:0]        irq_drive = '0;
    logic                                 req_drive = 1'b0;
    logic                                 allow_irq = 1'b0;
    logic                                 allow_dbg = 1'b0;
    logic [rv_arch_pkg::IRQ_ID_W-1:0]     want_irq_id = '0;
    logic                                 irq_allowed = 1'b0;
    logic                                 dbg_allowed = 1'b0;
    logic [rv_arch_pkg::IRQ_ID_W-1:0]     exp_irq_id = '0;

    logic [31:0]                          rng = 32'd49;
    int unsigned                          seq = 0;
    int                                   n_errors = 0;
    int                                   n_checks = 0;
    logic                                 gap_commit;
    logic                                 gap_valid;
    logic [31:0]                          mie_val;
    logic [31:0]                          mstatus_mie;
    shadow_pipe_pkg::instr_rec_t          dret;

    // Reference pipeline with IF at index 0, ID at 1 and EX at 2
    shadow_pipe_pkg::instr_rec_t          m_rec [3];
    shadow_pipe_pkg::instr_rec_t          m_wb_rec;
    logic [2:0]                           m_vld;
    logic                                 m_filling;
    int unsigned                          m_fill_cnt;
    logic                                 m_dbg_flush;
    logic                                 exp_retire;
    logic                                 s_wb;
    logic                                 s_front;
    logic                                 s_flush;

    retire_shadow_top UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic shadow_pipe_pkg::instr_rec_t new_rec(input logic dbg);
        shadow_pipe_pkg::instr_rec_t r;
        rng = xorshift(rng);
        seq = seq + 1;
        r = '0;
        r.order = seq;
        // Fixed low opcode bits keep a random word clear of DRET
        r.insn = {rng[31:7], 7'h13};
        r.csr_wdata = xorshift(rng);
        r.dbg_mode = dbg;
        return r;
    endfunction

    function automatic shadow_pipe_pkg::instr_rec_t csr_rec(input logic [11:0] addr,
                                                           input logic [31:0] data);
        shadow_pipe_pkg::instr_rec_t r;
        r = new_rec(1'b0);
        r.csr_we = 1'b1;
        r.csr_addr = addr;
        r.csr_wdata = data;
        return r;
    endfunction

    function automatic logic [rv_arch_pkg::IRQ_ID_W-1:0] lowest_line(input logic [31:0] lines);
        logic [rv_arch_pkg::IRQ_ID_W-1:0] id;
        logic                             found;
        id = '0;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (!found && lines[i]) begin
                id = i[rv_arch_pkg::IRQ_ID_W-1:0];
                found = 1'b1;
            end
        end
        return id;
    endfunction

    function automatic logic cond_met(input wait_kind_e kind);
        case (kind)
            WAIT_IRQ:        return irq_taken_o;
            WAIT_DBG:        return debug_taken_o;
            WAIT_DBG_RETIRE: return retire_valid_o && retire_rec_o.dbg_mode;
            default:         return retire_valid_o
                                    && (retire_rec_o.insn == rv_arch_pkg::INSN_DRET);
        endcase
    endfunction

    // Drives one cycle of stimulus and returns at the falling edge where outputs are stable
    task automatic tick(input logic commit, input shadow_pipe_pkg::instr_rec_t rec,
                        input logic valid);
        @(posedge clk);
        commit_i    <= commit;
        rec_i       <= rec;
        rec_valid_i <= valid;
        irq_i       <= irq_drive;
        debug_req_i <= req_drive;
        irq_allowed <= allow_irq;
        dbg_allowed <= allow_dbg;
        exp_irq_id  <= want_irq_id;
        @(negedge clk);
    endtask

    task automatic wait_for(input wait_kind_e kind, input logic commit, input logic dbg,
                            input int limit);
        int n;
        n = 0;
        while (!cond_met(kind) && n < limit) begin
            tick(commit, new_rec(dbg), 1'b1);
            n++;
        end
        if (!cond_met(kind)) begin
            n_errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, kind.name());
        end
    endtask

    ////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!retire_valid_o && !irq_taken_o && !debug_taken_o) else begin
                n_errors++;
                $display("FAILED at %0t: %s = %b, expected 000", $time,
                         "{retire_valid_o, irq_taken_o, debug_taken_o}",
                         {retire_valid_o, irq_taken_o, debug_taken_o});
            end
            m_vld       = '0;
            m_filling   = 1'b1;
            m_fill_cnt  = 0;
            m_dbg_flush = 1'b0;
            exp_retire  = 1'b0;
        end else begin
            n_checks++;
            assert (retire_valid_o == exp_retire) else begin
                n_errors++;
                $display("FAILED at %0t: retire_valid_o = %b, expected %b",
                         $time, retire_valid_o, exp_retire);
            end
            if (exp_retire) begin
                assert (retire_rec_o == m_wb_rec) else begin
                    n_errors++;
                    $display("FAILED at %0t: retire_rec_o = %h, expected %h",
                             $time, retire_rec_o, m_wb_rec);
                end
            end
            if (irq_taken_o) begin
                assert (irq_allowed) else begin
                    n_errors++;
                    $display("Interrupt taken at %0t although none could be taken", $time);
                end
                assert (!irq_allowed || irq_id_o == exp_irq_id) else begin
                    n_errors++;
                    $display("FAILED at %0t: irq_id_o = %0d, expected %0d",
                             $time, irq_id_o, exp_irq_id);
                end
            end
            assert (!debug_taken_o || dbg_allowed) else begin
                n_errors++;
                $display("Debug entry taken at %0t while in debug mode or unrequested", $time);
            end

            // Predict the next edge with fill steps first and then one step per commit
            s_wb    = m_filling || commit_i;
            s_front = s_wb && !debug_taken_o;
            s_flush = irq_taken_o || m_dbg_flush;
            exp_retire = s_wb && !s_flush && m_vld[2];
            if (s_wb) begin
                m_wb_rec = m_rec[2];
            end
            if (s_front) begin
                m_rec[2] = m_rec[1];
                m_rec[1] = m_rec[0];
                m_rec[0] = rec_i;
            end
            if (s_flush) begin
                m_vld      = '0;
                m_filling  = 1'b1;
                m_fill_cnt = 0;
            end else begin
                if (s_front) begin
                    m_vld = {m_vld[1:0], rec_valid_i};
                end
                if (m_filling) begin
                    m_fill_cnt++;
                    if (m_fill_cnt == shadow_pipe_pkg::FILL_STEPS) begin
                        m_filling = 1'b0;
                    end
                end
            end
            // A debug take flushes one cycle later
            m_dbg_flush = debug_taken_o;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        commit_i    = 1'b0;
        rec_i       = '0;
        rec_valid_i = 1'b0;
        irq_i       = '0;
        debug_req_i = 1'b0;
        mstatus_mie = 32'h1 << rv_arch_pkg::MSTATUS_MIE_BIT;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Fill and ordering with random commit gaps and some invalid records
        repeat (80) begin
            rng = xorshift(rng);
            gap_commit = (rng[1:0] != 2'b00);
            gap_valid  = (rng[4:2] != 3'b000);
            tick(gap_commit, new_rec(1'b0), gap_valid);
        end

        // Several interrupt lines are raised and the lowest enabled one wins
        irq_drive   = 32'h0000_0a50;
        mie_val     = 32'h0000_0a40;
        want_irq_id = lowest_line(irq_drive & mie_val);
        allow_irq   = 1'b1;
        tick(1'b1, csr_rec(rv_arch_pkg::CSR_MIE, mie_val), 1'b1);
        tick(1'b1, csr_rec(rv_arch_pkg::CSR_MSTATUS, mstatus_mie), 1'b1);
        wait_for(WAIT_IRQ, 1'b1, 1'b0, 40);
        allow_irq = 1'b0;
        repeat (8) tick(1'b1, new_rec(1'b0), 1'b1);
        // With MIE cleared the raised lines must stay ignored
        tick(1'b1, csr_rec(rv_arch_pkg::CSR_MIE, 32'h0), 1'b1);
        tick(1'b1, csr_rec(rv_arch_pkg::CSR_MSTATUS, mstatus_mie), 1'b1);
        repeat (40) tick(1'b1, new_rec(1'b0), 1'b1);
        irq_drive = '0;

        // Debug entry
        allow_dbg = 1'b1;
        req_drive = 1'b1;
        tick(1'b1, new_rec(1'b0), 1'b1);
        req_drive = 1'b0;
        wait_for(WAIT_DBG, 1'b1, 1'b0, 20);
        allow_dbg = 1'b0;

        // Requests inside debug mode are ignored
        wait_for(WAIT_DBG_RETIRE, 1'b1, 1'b1, 20);
        req_drive = 1'b1;
        repeat (20) tick(1'b1, new_rec(1'b1), 1'b1);
        req_drive = 1'b0;
        repeat (4) tick(1'b1, new_rec(1'b1), 1'b1);

        // DRET reaches WB after four steps and stays there once commits stop
        dret = new_rec(1'b1);
        dret.insn = rv_arch_pkg::INSN_DRET;
        tick(1'b1, dret, 1'b1);
        repeat (3) tick(1'b1, new_rec(1'b1), 1'b1);
        wait_for(WAIT_DRET_RETIRE, 1'b0, 1'b1, 4);
        allow_dbg = 1'b1;
        req_drive = 1'b1;
        wait_for(WAIT_DBG, 1'b0, 1'b1, 20);
        allow_dbg = 1'b0;
        req_drive = 1'b0;

        repeat (20) begin
            rng = xorshift(rng);
            tick(rng[0], new_rec(1'b0), 1'b1);
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hw/rv_arch_pkg.sv
hw/shadow_pipe_pkg.sv
hw/stage_ctrl_if.sv
hw/retire_pipe.sv
hw/irq_tracker.sv
hw/debug_tracker.sv
hw/step_flush_ctrl.sv
hw/retire_shadow_top.sv
testbench/tb_retire_shadow.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and decide on the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_retire_shadow \
    -f sim.f -o tb_retire_shadow > build.log 2>&1 \
    && ./obj_dir/tb_retire_shadow > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
